// File: Makefile
# Verilator flow for the serial packet bus testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_bus
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bus_arbiter.sv
// Rotating-pointer arbiter for the shared line. Needs num_nodes >= 2.
// A grant is held while its request is held and cleared one edge after.

`timescale 1ns/10ps

module bus_arbiter #(
  parameter int num_nodes = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_nodes-1:0] req,
  input  logic [num_nodes-1:0] tx_bit,
  input  logic [num_nodes-1:0] tx_valid,
  output logic [num_nodes-1:0] grant,
  output logic                 bus_data,
  output logic                 bus_valid
);

  localparam int PTR_W = $clog2(num_nodes);

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] ptr_next;
  logic             busy;

  assign ptr_next = (ptr == PTR_W'(num_nodes - 1)) ? '0 : ptr + 1'b1;
  assign busy     = |grant;

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and grant
  ////////////////////////////////////////////////////////////////////////////

  // The granted node is always the one under the pointer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ptr   <= '0;
      grant <= '0;
    end else if (busy) begin
      if (!req[ptr]) begin
        grant <= '0;
        ptr   <= ptr_next;
      end
    end else if (req[ptr]) begin
      grant <= {{(num_nodes-1){1'b0}}, 1'b1} << ptr;
    end else if (|req) begin
      // Skip an idle node only when someone else is waiting
      ptr <= ptr_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line multiplexer
  ////////////////////////////////////////////////////////////////////////////

  // Grant is one-hot or zero, so an AND-OR picks the sender
  assign bus_data  = |(grant & tx_bit);
  assign bus_valid = |(grant & tx_valid);

endmodule

// File: bus_cases.txt
// One packet case per line, all hex
// source node, destination id, payload
0 01 3c
1 02 5a
3 00 7e
2 ff 99
2 02 11
0 20 ee
0 03 a1
1 ff b2
2 01 c3
3 02 d4
0 02 e5
3 ff f6

// File: bus_node.sv
// One bus node. Transmit and receive paths run independently.
// d_push shows the word in the push cycle and holds it afterwards.

`timescale 1ns/10ps

module bus_node
  import bus_pkg::*;
#(
  parameter int       pkt_w   = 16,
  parameter node_id_t node_id = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             pndng,
  input  logic             grant,
  input  logic             bus_data,
  input  logic             bus_valid,
  input  logic [pkt_w-1:0] d_pop,
  output logic             req,
  output logic             pop,
  output logic             push,
  output logic             tx_bit,
  output logic             tx_valid,
  output logic [pkt_w-1:0] d_push
);

  logic             load;
  logic             tx_shift;
  logic             rx_shift;
  logic [pkt_w-1:0] rx_word;
  logic [pkt_w-1:0] last_word;

  // Transmit path
  packet_tx #(.pkt_w(pkt_w)) tx_inst (
    .clk(clk), .rst(rst), .pndng(pndng), .grant(grant), .req(req), .pop(pop),
    .load(load), .shift_en(tx_shift), .tx_valid(tx_valid)
  );

  shift_reg #(.pkt_w(pkt_w)) tx_sr (
    .clk(clk), .rst(rst), .en(tx_shift), .load(load), .ser_in(1'b0),
    .par_in(d_pop), .ser_out(tx_bit), .par_out()
  );

  // Receive path
  packet_rx #(.pkt_w(pkt_w), .node_id(node_id)) rx_inst (
    .clk(clk), .rst(rst), .bus_valid(bus_valid), .own_grant(grant),
    .rx_word(rx_word), .shift_en(rx_shift), .push(push)
  );

  shift_reg #(.pkt_w(pkt_w)) rx_sr (
    .clk(clk), .rst(rst), .en(rx_shift), .load(1'b0), .ser_in(bus_data),
    .par_in('0), .ser_out(), .par_out(rx_word)
  );

  // Keep the delivered word while other traffic passes through rx_sr
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_word <= '0;
    end else if (push) begin
      last_word <= rx_word;
    end
  end

  assign d_push = push ? rx_word : last_word;

endmodule

// File: bus_pkg.sv
// Shared definitions for the serial packet bus.
// The destination id sits in the top ADDR_W bits of every packet.

package bus_pkg;

  // Width of the destination field at the top of a packet
  parameter int ADDR_W = 8;

  // Node or destination id
  typedef logic [ADDR_W-1:0] node_id_t;

  // All ones reaches every node except the sender
  parameter node_id_t BROADCAST_ID = '1;

  // Transmitter states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    SEND
  } tx_state_t;

endpackage

// File: filelist.f
bus_pkg.sv
shift_reg.sv
packet_tx.sv
packet_rx.sv
bus_arbiter.sv
bus_node.sv
serial_bus.sv
serial_bus_assert.sv
tb_serial_bus.sv

// File: packet_rx.sv
// Receive control for one node. Needs pkt_w >= ADDR_W + 1.
// Push comes one cycle after the last bit, with no way to stall.

`timescale 1ns/10ps

module packet_rx
  import bus_pkg::*;
#(
  parameter int       pkt_w   = 16,
  parameter node_id_t node_id = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             bus_valid,
  input  logic             own_grant,
  input  logic [pkt_w-1:0] rx_word,
  output logic             shift_en,
  output logic             push
);

  localparam int CNT_W = $clog2(pkt_w);

  logic [CNT_W-1:0] bit_cnt;
  logic             last_bit;
  node_id_t         dst;
  logic             hit;

  // Own transmissions are not received
  assign shift_en = bus_valid && !own_grant;
  assign last_bit = shift_en && (bit_cnt == CNT_W'(pkt_w - 1));

  // Destination as it will sit at the top once the last bit is shifted in
  assign dst = rx_word[pkt_w-2 -: ADDR_W];
  assign hit = (dst == node_id) || (dst == BROADCAST_ID);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
      push    <= 1'b0;
    end else begin
      push <= last_bit && hit;
      if (last_bit) begin
        bit_cnt <= '0;
      end else if (shift_en) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// File: packet_tx.sv
// Transmit control for one node. Pops once per grant and sends pkt_w bits.
// Request stays up until the last bit is on the line.

`timescale 1ns/10ps

module packet_tx
  import bus_pkg::*;
#(
  parameter int pkt_w = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic pndng,
  input  logic grant,
  output logic req,
  output logic pop,
  output logic load,
  output logic shift_en,
  output logic tx_valid
);

  localparam int CNT_W = $clog2(pkt_w);

  tx_state_t        state;
  logic [CNT_W-1:0] bit_cnt;
  logic             last_bit;

  assign last_bit = (bit_cnt == CNT_W'(pkt_w - 1));

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (pndng) begin
            state <= REQ;
          end
        end
        REQ: begin
          // Packet is popped and loaded in this cycle
          if (grant) begin
            state   <= SEND;
            bit_cnt <= '0;
          end
        end
        SEND: begin
          if (last_bit) begin
            state <= IDLE;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign req      = (state != IDLE);
  assign pop      = (state == REQ) && grant;
  assign load     = pop;
  assign shift_en = (state == SEND);
  assign tx_valid = shift_en;

endmodule

// File: serial_bus.sv
// Serial packet bus top with a central arbiter. Node ids are 0 .. num_nodes-1.
// No back-pressure: d_push must be taken in its push cycle.

`timescale 1ns/10ps

module serial_bus
  import bus_pkg::*;
#(
  parameter int num_nodes = 4,
  parameter int pkt_w     = 16
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [num_nodes-1:0]            pndng,
  input  logic [num_nodes-1:0][pkt_w-1:0] d_pop,
  output logic [num_nodes-1:0]            pop,
  output logic [num_nodes-1:0]            push,
  output logic [num_nodes-1:0][pkt_w-1:0] d_push
);

  logic [num_nodes-1:0] req;
  logic [num_nodes-1:0] grant;
  logic [num_nodes-1:0] tx_bit;
  logic [num_nodes-1:0] tx_valid;
  logic                 bus_data;
  logic                 bus_valid;

  for (genvar i = 0; i < num_nodes; i++) begin : g_node
    bus_node #(.pkt_w(pkt_w), .node_id(node_id_t'(i))) node_inst (
      .clk(clk), .rst(rst), .pndng(pndng[i]), .grant(grant[i]),
      .bus_data(bus_data), .bus_valid(bus_valid), .d_pop(d_pop[i]),
      .req(req[i]), .pop(pop[i]), .push(push[i]), .tx_bit(tx_bit[i]),
      .tx_valid(tx_valid[i]), .d_push(d_push[i])
    );
  end

  bus_arbiter #(.num_nodes(num_nodes)) arb_inst (
    .clk(clk), .rst(rst), .req(req), .tx_bit(tx_bit), .tx_valid(tx_valid),
    .grant(grant), .bus_data(bus_data), .bus_valid(bus_valid)
  );

endmodule

// File: serial_bus_assert.sv
// Properties of the serial_bus top level, attached by bind.
// Relies on the sender's grant staying up through the push cycle of its packet.

`timescale 1ns/10ps

module serial_bus_assert #(
  parameter int num_nodes = 4,
  parameter int pkt_w     = 16
) (
  input logic                 clk,
  input logic                 rst,
  input logic [num_nodes-1:0] pndng,
  input logic [num_nodes-1:0] pop,
  input logic [num_nodes-1:0] push,
  input logic [num_nodes-1:0] grant
);

  logic        multi_pop = 1'b0;
  logic        stray_pop = 1'b0;
  logic        self_push = 1'b0;
  logic        close_pop = 1'b0;
  logic        failed;
  int unsigned since_pop;

  assign failed = multi_pop | stray_pop | self_push | close_pop;

  // Cycles since the last pop, saturating at the minimum spacing
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      since_pop <= pkt_w + 1;
    end else if (|pop) begin
      since_pop <= 0;
    end else if (since_pop < pkt_w + 1) begin
      since_pop <= since_pop + 1;
    end
  end

  one_pop: assert property (@(posedge clk) disable iff (rst) $onehot0(pop)) else begin
    $error("More than one pop in one cycle");
    multi_pop = 1'b1;
  end

  pop_pending: assert property (@(posedge clk) disable iff (rst) (pop & ~pndng) == '0)
  else begin
    $error("Pop at a node without a pending packet");
    stray_pop = 1'b1;
  end

  no_self_push: assert property (@(posedge clk) disable iff (rst) (push & grant) == '0)
  else begin
    $error("Push at the node that sent the packet");
    self_push = 1'b1;
  end

  pop_spacing: assert property (@(posedge clk) disable iff (rst)
                                (|pop) |-> (since_pop >= pkt_w + 1)) else begin
    $error("Pop pulses closer than pkt_w + 2 cycles");
    close_pop = 1'b1;
  end

endmodule

bind serial_bus serial_bus_assert #(.num_nodes(num_nodes), .pkt_w(pkt_w)) assert_inst (
  .clk(clk), .rst(rst), .pndng(pndng), .pop(pop), .push(push), .grant(grant)
);

// File: shift_reg.sv
// Parallel-load shift register, MSB out first, serial input enters at bit 0.
// Load has priority over shift.

`timescale 1ns/10ps

module shift_reg #(
  parameter int pkt_w = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  logic             load,
  input  logic             ser_in,
  input  logic [pkt_w-1:0] par_in,
  output logic             ser_out,
  output logic [pkt_w-1:0] par_out
);

  logic [pkt_w-1:0] data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data <= '0;
    end else if (load) begin
      data <= par_in;
    end else if (en) begin
      // Shift toward the MSB
      data <= {data[pkt_w-2:0], ser_in};
    end
  end

  assign ser_out = data[pkt_w-1];
  assign par_out = data;

endmodule

// File: tb_serial_bus.sv
// Testbench for serial_bus with 4 nodes and 16-bit packets read from bus_cases.txt.
// The first solo_cases cases are spaced apart and the rest are released together.

`timescale 1ns/10ps

module tb_serial_bus;
  import bus_pkg::*;

  localparam int num_nodes    = 4;
  localparam int pkt_w        = 16;
  localparam int max_cases    = 32;
  localparam int solo_cases   = 6;
  localparam int reset_cycles = 16;

  logic                            clk   = 1'b0;
  logic                            rst   = 1'b1;
  logic [num_nodes-1:0]            pndng = '0;
  logic [num_nodes-1:0][pkt_w-1:0] d_pop = '0;
  logic [num_nodes-1:0]            pop;
  logic [num_nodes-1:0]            push;
  logic [num_nodes-1:0][pkt_w-1:0] d_push;

  // Three words per case
  logic [7:0] case_mem [0:3*max_cases-1];
  int         gap [0:max_cases-1];
  int         num_cases;
  int         limit;
  int         cyc;
  int         released;
  int         gap_left;
  int         popped;
  int         pending;

  // Source queues, then expected words and due cycles per receiver
  logic [pkt_w-1:0] src_q [num_nodes][$];
  logic [pkt_w-1:0] exp_q [num_nodes][$];
  int               due_q [num_nodes][$];

  // Last word delivered at each node, valid once a delivery has happened
  logic [pkt_w-1:0]     held [num_nodes];
  logic [num_nodes-1:0] held_ok = '0;

  serial_bus #(.num_nodes(num_nodes), .pkt_w(pkt_w)) serial_bus_inst (
    .clk(clk), .rst(rst), .pndng(pndng), .d_pop(d_pop), .pop(pop), .push(push),
    .d_push(d_push)
  );

  always #20 clk = ~clk;

  task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual,
               expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at first error");
    end
  endtask

  // Head of each source queue is presented as the pending packet
  always @(posedge clk) begin
    for (int n = 0; n < num_nodes; n++) begin
      pndng[n] <= (src_q[n].size() != 0);
      d_pop[n] <= (src_q[n].size() != 0) ? src_q[n][0] : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard and case release, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    logic [pkt_w-1:0] pkt;
    node_id_t         dst;
    cyc++;
    if (cyc > limit) begin
      $display("Timeout after %0d cycles with %0d deliveries outstanding", limit, pending);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout");
    end else if (!rst) begin
      expect_equal(serial_bus_inst.assert_inst.failed, 1'b0, "bound assertion");
      for (int n = 0; n < num_nodes; n++) begin
        if (due_q[n].size() != 0 && due_q[n][0] == cyc) begin
          expect_equal(push[n], 1'b1, $sformatf("push at node %0d in cycle %0d", n, cyc));
          expect_equal(d_push[n], exp_q[n][0], $sformatf("d_push at node %0d", n));
          held[n]    = exp_q[n][0];
          held_ok[n] = 1'b1;
          void'(due_q[n].pop_front());
          void'(exp_q[n].pop_front());
          pending--;
        end else begin
          expect_equal(push[n], 1'b0, $sformatf("idle push at node %0d in cycle %0d", n, cyc));
          if (held_ok[n]) begin
            expect_equal(d_push[n], held[n], $sformatf("held d_push at node %0d", n));
          end
        end
      end
      for (int n = 0; n < num_nodes; n++) begin
        if (pop[n]) begin
          expect_equal(src_q[n].size() != 0, 1'b1, $sformatf("pop at node %0d", n));
          pkt = src_q[n].pop_front();
          dst = pkt[pkt_w-1 -: ADDR_W];
          // Sender never hears its own packet
          for (int r = 0; r < num_nodes; r++) begin
            if (r != n && (dst == BROADCAST_ID || dst == node_id_t'(r))) begin
              due_q[r].push_back(cyc + pkt_w + 1);
              exp_q[r].push_back(pkt);
              pending++;
            end
          end
          popped++;
        end
      end
      if (gap_left > 0) begin
        gap_left--;
      end else begin
        while (released < num_cases && gap_left == 0) begin
          expect_equal(case_mem[3*released] < num_nodes, 1'b1, "source node in range");
          src_q[case_mem[3*released]].push_back({case_mem[3*released+1],
                                                 case_mem[3*released+2]});
          released++;
          if (released < num_cases) begin
            gap_left = gap[released];
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(79224));
    for (int i = 0; i < 3*max_cases; i++) begin
      // Bit 7 marks an entry the case file did not fill
      case_mem[i] = 8'h80 | 8'(i);
    end
    $readmemh("bus_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < max_cases && !case_mem[3*num_cases][7]) begin
      num_cases++;
    end
    expect_equal(num_cases != 0, 1'b1, "cases read from bus_cases.txt");
    limit = reset_cycles + num_cases * (pkt_w + num_nodes + 4);
    for (int i = 0; i < num_cases; i++) begin
      gap[i] = (i < solo_cases) ? 2 * pkt_w + int'($urandom % 16) : 0;
      limit += gap[i];
    end
    gap_left = gap[0];
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    // Done once every case is popped and every delivery has arrived
    while (released < num_cases || popped < num_cases || pending != 0) begin
      @(posedge clk);
    end
    // Assertion actions for this edge run after the edge itself
    #1;
    if (serial_bus_inst.assert_inst.failed) begin
      $display("A bound assertion failed during the run");
      $display("TEST RESULT: FAIL");
      $fatal(1, "Assertion failure");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule
